//--- design/cbm_cfg_pkg.sv
`default_nettype none

package cbm_cfg_pkg;

	// System presets, in menu order
	typedef enum logic [2:0] {
		SYS_P500   = 3'd0,
		SYS_B610   = 3'd1,
		SYS_B620   = 3'd2,
		SYS_B710   = 3'd3,
		SYS_B720   = 3'd4,
		SYS_CUSTOM = 3'd5
	} sys_preset_e;

	typedef enum logic {
		MODEL_P = 1'b0,
		MODEL_B = 1'b1
	} model_e;

	typedef enum logic [1:0] {
		RAM_128K = 2'd0,
		RAM_256K = 2'd1,
		RAM_896K = 2'd2
	} ramsize_e;

	// Status bits 10..2, read through the preset field only
	typedef struct packed {
		logic [5:0]  pad;
		sys_preset_e system;
	} cfg_preset_t;

	// Same bits with the custom hardware fields broken out
	typedef struct packed {
		logic        spare;
		logic [1:0]  ram_sel;
		logic        rsvd;
		logic [1:0]  model_sel;
		sys_preset_e system;
	} cfg_custom_t;

	typedef union packed {
		cfg_preset_t preset;
		cfg_custom_t custom;
	} cfg_word_u;

	// Last erased address per model and RAM size
	localparam logic [24:0] ERASE_END_P128 = 25'h001_FFFF;
	localparam logic [24:0] ERASE_END_B128 = 25'h002_FFFF;
	localparam logic [24:0] ERASE_END_P256 = 25'h003_FFFF;
	localparam logic [24:0] ERASE_END_B256 = 25'h004_FFFF;
	localparam logic [24:0] ERASE_END_FULL = 25'h00E_FFFF;

	// Bank 0 holds no RAM on the B machines
	localparam logic [24:0] ERASE_START_B  = 25'h001_0000;

endpackage

`default_nettype wire

//--- design/mem_xfer_pkg.sv
`default_nettype none

package mem_xfer_pkg;

	localparam int RAM_AW = 25;

	// One byte write headed for main RAM
	typedef struct packed {
		logic [RAM_AW-1:0] addr;
		logic [7:0]        data;
	} wr_req_t;

	// Memory-side port as seen by the SDRAM controller
	typedef struct packed {
		logic              ce;
		logic              we;
		logic [RAM_AW-1:0] addr;
		logic [7:0]        data;
	} ram_port_t;

	// PRG payload lands in the first user bank of each model
	localparam logic [8:0] PRG_BANK_P   = 9'h000;
	localparam logic [8:0] PRG_BANK_B   = 9'h001;

	// BASIC zero page lives in bank 15
	localparam logic [8:0] MEMINIT_BANK = 9'h00F;
	localparam logic [7:0] PTR_TXTTAB   = 8'h2D;
	localparam logic [7:0] PTR_TXTEND   = 8'h2F;

endpackage

`default_nettype wire

//--- design/sys_config_decode.sv
`timescale 1ns/1ps
`default_nettype none

module sys_config_decode
	import cbm_cfg_pkg::*;
(
	input  cfg_word_u   cfg_i,
	output model_e      model_o,
	output ramsize_e    ramsize_o,
	output logic [24:0] erase_start_o,
	output logic [24:0] erase_end_o
);

	sys_preset_e preset;

	assign preset = cfg_i.preset.system;

	always_comb begin
		if (preset == SYS_CUSTOM) begin
			model_o   = (|cfg_i.custom.model_sel) ? MODEL_B : MODEL_P;
			// Select value 3 is not offered, treat it as the full map
			ramsize_o = cfg_i.custom.ram_sel[1] ? RAM_896K : ramsize_e'(cfg_i.custom.ram_sel);
		end else begin
			model_o = (preset == SYS_P500) ? MODEL_P : MODEL_B;
			if (preset == SYS_P500 || preset == SYS_B610 || preset == SYS_B710)
				ramsize_o = RAM_128K;
			else
				ramsize_o = RAM_256K;
		end
	end

	// Erase range
	always_comb begin
		erase_start_o = (model_o == MODEL_B) ? ERASE_START_B : '0;
		case (ramsize_o)
			RAM_128K: erase_end_o = (model_o == MODEL_B) ? ERASE_END_B128 : ERASE_END_P128;
			RAM_256K: erase_end_o = (model_o == MODEL_B) ? ERASE_END_B256 : ERASE_END_P256;
			default:  erase_end_o = ERASE_END_FULL;
		endcase
	end

endmodule

`default_nettype wire

//--- design/mem_write_gen.sv
`timescale 1ns/1ps
`default_nettype none

module mem_write_gen
	import cbm_cfg_pkg::*;
	import mem_xfer_pkg::*;
(
	input  logic              clk_sys,
	input  logic              RESET,

	input  model_e            model_i,
	input  logic [RAM_AW-1:0] erase_start_i,
	input  logic [RAM_AW-1:0] erase_end_i,

	input  logic              dl_active_i,
	input  logic              dl_valid_i,
	input  logic [7:0]        dl_byte_i,
	output logic              dl_ready_o,

	input  logic              erase_req_i,
	output logic              erase_busy_o,

	output wr_req_t           req_o,
	output logic              req_valid_o,
	input  logic              req_ready_i
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_LOAD,
		S_INJ,
		S_ERASE
	} gen_state_e;

	gen_state_e        state_q, state_n;
	logic [1:0]        hdr_q, hdr_n;
	logic [15:0]       txt_start_q, txt_start_n;
	logic [15:0]       txt_end_q, txt_end_n;
	logic [1:0]        ptr_idx_q, ptr_idx_n;
	logic [RAM_AW-1:0] erase_addr_q, erase_addr_n;
	wr_req_t           req_q, req_n;
	logic              req_valid_q, req_valid_n;
	logic              dl_ready_q, dl_ready_n;
	logic              busy_q, busy_n;

	logic              out_free;
	logic              dl_fire;
	logic [8:0]        prg_bank;
	logic [7:0]        ptr_off;
	logic [7:0]        ptr_data;
	logic [7:0]        erase_fill;

	// Output register empties this edge or already is
	assign out_free = !req_valid_q || req_ready_i;
	assign dl_fire  = dl_valid_i && dl_ready_q;
	assign prg_bank = (model_i == MODEL_B) ? PRG_BANK_B : PRG_BANK_P;

	// =====================================================================
	// BASIC pointer bytes, TXTTAB then TXTEND, low byte first
	// =====================================================================
	assign ptr_off = (ptr_idx_q[1] ? PTR_TXTEND : PTR_TXTTAB) + {7'd0, ptr_idx_q[0]};

	always_comb begin
		case (ptr_idx_q)
			2'd0:    ptr_data = txt_start_q[7:0];
			2'd1:    ptr_data = txt_start_q[15:8];
			2'd2:    ptr_data = txt_end_q[7:0];
			default: ptr_data = txt_end_q[15:8];
		endcase
	end

	// Checkerboard fill
	assign erase_fill = {8{erase_addr_q[14] ^ erase_addr_q[3] ^ erase_addr_q[2]}};

	// =====================================================================
	// Next state
	// =====================================================================
	always_comb begin
		state_n      = state_q;
		hdr_n        = hdr_q;
		txt_start_n  = txt_start_q;
		txt_end_n    = txt_end_q;
		ptr_idx_n    = ptr_idx_q;
		erase_addr_n = erase_addr_q;
		req_n        = req_q;
		req_valid_n  = req_valid_q && !req_ready_i;

		// Byte 0/1 is the load address, the rest is payload
		if (dl_fire) begin
			case (hdr_q)
				2'd0: begin
					txt_start_n[7:0] = dl_byte_i;
					txt_end_n[7:0]   = dl_byte_i;
					hdr_n            = 2'd1;
				end
				2'd1: begin
					txt_start_n[15:8] = dl_byte_i;
					txt_end_n[15:8]   = dl_byte_i;
					hdr_n             = 2'd2;
				end
				default: begin
					req_n.addr  = {prg_bank, txt_end_q};
					req_n.data  = dl_byte_i;
					req_valid_n = 1'b1;
					txt_end_n   = txt_end_q + 16'd1;
				end
			endcase
		end

		case (state_q)
			S_IDLE: begin
				if (erase_req_i) begin
					state_n      = S_ERASE;
					erase_addr_n = erase_start_i;
				end else if (dl_active_i) begin
					state_n = S_LOAD;
				end
			end
			S_LOAD: begin
				// End of download kicks off the pointer writes
				if (!dl_active_i) begin
					state_n   = S_INJ;
					ptr_idx_n = '0;
				end
			end
			S_INJ: begin
				if (out_free) begin
					req_n.addr  = {MEMINIT_BANK, 8'h00, ptr_off};
					req_n.data  = ptr_data;
					req_valid_n = 1'b1;
					ptr_idx_n   = ptr_idx_q + 2'd1;
					if (ptr_idx_q == 2'd3) begin
						state_n = S_IDLE;
						hdr_n   = '0;
					end
				end
			end
			default: begin
				if (out_free) begin
					req_n.addr  = erase_addr_q;
					req_n.data  = erase_fill;
					req_valid_n = 1'b1;
					if (erase_addr_q == erase_end_i)
						state_n = S_IDLE;
					else
						erase_addr_n = erase_addr_q + 1'b1;
				end
			end
		endcase

		// Busy until the last fill byte has left for the FIFO
		busy_n     = (state_n == S_ERASE) || (busy_q && req_valid_n);
		dl_ready_n = (state_n == S_IDLE || state_n == S_LOAD) && !req_valid_n && !busy_n;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state_q     <= S_IDLE;
			hdr_q       <= '0;
			ptr_idx_q   <= '0;
			req_valid_q <= 1'b0;
			dl_ready_q  <= 1'b0;
			busy_q      <= 1'b0;
		end else begin
			state_q     <= state_n;
			hdr_q       <= hdr_n;
			ptr_idx_q   <= ptr_idx_n;
			req_valid_q <= req_valid_n;
			dl_ready_q  <= dl_ready_n;
			busy_q      <= busy_n;
		end
		txt_start_q  <= txt_start_n;
		txt_end_q    <= txt_end_n;
		erase_addr_q <= erase_addr_n;
		req_q        <= req_n;
	end

	assign req_o        = req_q;
	assign req_valid_o  = req_valid_q;
	assign dl_ready_o   = dl_ready_q;
	assign erase_busy_o = busy_q;

endmodule

`default_nettype wire

//--- design/write_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module write_fifo
	import mem_xfer_pkg::*;
#(
	parameter int DEPTH = 4
) (
	input  logic    clk_sys,
	input  logic    RESET,

	input  wr_req_t in_i,
	input  logic    in_valid_i,
	output logic    in_ready_o,

	output wr_req_t out_o,
	output logic    out_valid_o,
	input  logic    out_ready_i
);

	localparam int AW = $clog2(DEPTH);

	wr_req_t       mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          push;
	logic          pop;

	assign in_ready_o  = (count != (AW+1)'(DEPTH));
	assign out_valid_o = (count != '0);
	assign out_o       = mem[rd_ptr];

	assign push = in_valid_i && in_ready_o;
	assign pop  = out_valid_o && out_ready_i;

	// Pointers wrap naturally, depth is a power of two
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge clk_sys) begin
		if (push)
			mem[wr_ptr] <= in_i;
	end

endmodule

`default_nettype wire

//--- design/sdram_slot_writer.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_slot_writer
	import mem_xfer_pkg::*;
(
	input  logic      clk_sys,
	input  logic      RESET,

	input  wr_req_t   req_i,
	input  logic      req_valid_i,
	output logic      req_ready_o,

	input  logic      slot_i,
	output ram_port_t ram_o
);

	logic fire;

	// A request can only leave in a granted slot
	assign req_ready_o = slot_i;
	assign fire        = slot_i && req_valid_i;

	// =====================================================================
	// Memory strobe, one cycle per accepted request
	// =====================================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ram_o.ce <= 1'b0;
			ram_o.we <= 1'b0;
		end else begin
			ram_o.ce <= fire;
			ram_o.we <= fire;
		end
	end

	// Address and data only change with a new write
	always_ff @(posedge clk_sys) begin
		if (fire) begin
			ram_o.addr <= req_i.addr;
			ram_o.data <= req_i.data;
		end
	end

endmodule

`default_nettype wire

//--- design/cbm_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

module cbm_loader_top
	import cbm_cfg_pkg::*;
	import mem_xfer_pkg::*;
#(
	parameter int DEPTH = 4
) (
	input  logic       clk_sys,
	input  logic       RESET,

	// PRG download stream
	input  logic       dl_active_i,
	input  logic       dl_valid_i,
	input  logic [7:0] dl_byte_i,
	output logic       dl_ready_o,

	input  logic       erase_req_i,
	output logic       erase_busy_o,

	input  cfg_word_u  cfg_i,

	// Memory side
	input  logic       slot_i,
	output ram_port_t  ram_o
);

	model_e            model;
	logic [RAM_AW-1:0] erase_start;
	logic [RAM_AW-1:0] erase_end;

	wr_req_t           gen_req;
	logic              gen_valid;
	logic              gen_ready;
	wr_req_t           fifo_req;
	logic              fifo_valid;
	logic              fifo_ready;

	// RAM size only shapes the erase range here
	sys_config_decode u_cfg (
		.cfg_i         (cfg_i),
		.model_o       (model),
		.ramsize_o     (),
		.erase_start_o (erase_start),
		.erase_end_o   (erase_end)
	);

	mem_write_gen u_gen (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.model_i       (model),
		.erase_start_i (erase_start),
		.erase_end_i   (erase_end),
		.dl_active_i   (dl_active_i),
		.dl_valid_i    (dl_valid_i),
		.dl_byte_i     (dl_byte_i),
		.dl_ready_o    (dl_ready_o),
		.erase_req_i   (erase_req_i),
		.erase_busy_o  (erase_busy_o),
		.req_o         (gen_req),
		.req_valid_o   (gen_valid),
		.req_ready_i   (gen_ready)
	);

	write_fifo #(
		.DEPTH (DEPTH)
	) u_fifo (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.in_i        (gen_req),
		.in_valid_i  (gen_valid),
		.in_ready_o  (gen_ready),
		.out_o       (fifo_req),
		.out_valid_o (fifo_valid),
		.out_ready_i (fifo_ready)
	);

	sdram_slot_writer u_wr (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.req_i       (fifo_req),
		.req_valid_i (fifo_valid),
		.req_ready_o (fifo_ready),
		.slot_i      (slot_i),
		.ram_o       (ram_o)
	);

endmodule

`default_nettype wire

//--- tests/tb_cbm_loader_sva.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cbm_loader_sva
	import mem_xfer_pkg::*;
(
	input logic      clk_sys,
	input logic      RESET,
	input logic      slot_i,
	input logic      dl_ready_o,
	input logic      erase_busy_o,
	input ram_port_t ram_o
);

	// RAM strobe follows a granted slot by one cycle
	strobe_after_slot: assert property (@(posedge clk_sys) disable iff (RESET)
		(ram_o.ce || ram_o.we) |-> $past(slot_i))
		else $error("ram_o strobe without a slot in the previous cycle");

	// Quiet memory port and no erase while held in reset
	quiet_in_reset: assert property (@(posedge clk_sys)
		RESET |=> (!ram_o.ce && !ram_o.we && !erase_busy_o))
		else $error("ram_o strobe or erase_busy_o during reset");

	// Download stream is closed for the whole erase
	no_dl_during_erase: assert property (@(posedge clk_sys) disable iff (RESET)
		erase_busy_o |-> !dl_ready_o)
		else $error("dl_ready_o high while erase_busy_o is high");

endmodule

bind cbm_loader_top tb_cbm_loader_sva u_sva (
	.clk_sys      (clk_sys),
	.RESET        (RESET),
	.slot_i       (slot_i),
	.dl_ready_o   (dl_ready_o),
	.erase_busy_o (erase_busy_o),
	.ram_o        (ram_o)
);

`default_nettype wire

//--- tests/tb_cbm_loader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cbm_loader
	import cbm_cfg_pkg::*;
	import mem_xfer_pkg::*;
();

	localparam int FIFO_DEPTH = 4;

	logic        clk_sys;
	logic        RESET;
	logic        dl_active_i;
	logic        dl_valid_i;
	logic [7:0]  dl_byte_i;
	logic        dl_ready_o;
	logic        erase_req_i;
	logic        erase_busy_o;
	cfg_word_u   cfg_i;
	logic        slot_i;
	ram_port_t   ram_o;

	// Context of the running test, read by the reference model
	logic        erase_mode;
	logic [8:0]  prg_bank;
	logic [15:0] load_addr;
	int          prg_len;
	int          pool_base;
	logic [24:0] erase_first;
	int          expected_total;
	int          writes_seen;
	logic [7:0]  data_pool [256];

	integer      seed;
	int          slot_gap = 2;
	int          errors;
	int          checks;
	int          tests_run;
	logic        timed_out;

	cbm_loader_top #(
		.DEPTH (FIFO_DEPTH)
	) dut (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl_active_i  (dl_active_i),
		.dl_valid_i   (dl_valid_i),
		.dl_byte_i    (dl_byte_i),
		.dl_ready_o   (dl_ready_o),
		.erase_req_i  (erase_req_i),
		.erase_busy_o (erase_busy_o),
		.cfg_i        (cfg_i),
		.slot_i       (slot_i),
		.ram_o        (ram_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// Random slot grants, sparse when slot_gap is large
	initial begin
		slot_i = 1'b0;
		forever begin
			@(negedge clk_sys);
			slot_i = !RESET && (($unsigned($random(seed)) % slot_gap) == 0);
		end
	end

	// ==================================================================
	// Reference model
	// ==================================================================
	function automatic wr_req_t ref_write(input int n);
		wr_req_t     w;
		logic [24:0] a;
		logic [15:0] txt_end;
		int          k;
		txt_end = load_addr + 16'(prg_len);
		k       = n - prg_len;
		if (erase_mode) begin
			a      = erase_first + 25'(n);
			w.addr = a;
			w.data = {8{a[14] ^ a[3] ^ a[2]}};
		end else if (n < prg_len) begin
			w.addr = {prg_bank, load_addr + 16'(n)};
			w.data = data_pool[8'(pool_base + n)];
		end else begin
			// TXTTAB lo/hi, then TXTEND lo/hi
			w.addr = {MEMINIT_BANK, 8'h00, PTR_TXTTAB + 8'(k)};
			case (k)
				0:       w.data = load_addr[7:0];
				1:       w.data = load_addr[15:8];
				2:       w.data = txt_end[7:0];
				default: w.data = txt_end[15:8];
			endcase
		end
		return w;
	endfunction

	function automatic cfg_word_u preset_cfg(input sys_preset_e sys);
		cfg_word_u c;
		c = '0;
		c.preset.system = sys;
		return c;
	endfunction

	function automatic cfg_word_u custom_cfg(input logic [1:0] model_sel, input logic [1:0] ram_sel);
		cfg_word_u c;
		c = '0;
		c.custom.system    = SYS_CUSTOM;
		c.custom.model_sel = model_sel;
		c.custom.ram_sel   = ram_sel;
		return c;
	endfunction

	// Every RAM strobe against the n-th expected write
	always @(negedge clk_sys) begin : compare
		wr_req_t exp_w;
		if (!RESET && (ram_o.ce || ram_o.we)) begin
			checks++;
			if (writes_seen >= expected_total) begin
				$display("Extra RAM write at %0t to address %h", $time, ram_o.addr);
				errors++;
			end else begin
				exp_w = ref_write(writes_seen);
				if (!(ram_o.ce && ram_o.we)) begin
					$display("FAIL t=%0t ram_o.ce/we expected 11 got %b%b",
						$time, ram_o.ce, ram_o.we);
					errors++;
				end
				if (ram_o.addr !== exp_w.addr) begin
					$display("FAIL t=%0t ram_o.addr expected %h got %h",
						$time, exp_w.addr, ram_o.addr);
					errors++;
				end
				if (ram_o.data !== exp_w.data) begin
					$display("FAIL t=%0t ram_o.data expected %h got %h",
						$time, exp_w.data, ram_o.data);
					errors++;
				end
			end
			writes_seen++;
		end
	end

	// ==================================================================
	// Test tasks
	// ==================================================================
	task automatic report_timeout(input string what);
		$display("Timeout at %0t, no progress while waiting for %s", $time, what);
		errors++;
		timed_out = 1'b1;
	endtask

	task automatic close_test(input string name, input int err0);
		repeat (30) @(negedge clk_sys);
		checks += 2;
		if (writes_seen != expected_total) begin
			$display("FAIL t=%0t writes_seen expected %0d got %0d",
				$time, expected_total, writes_seen);
			errors++;
		end
		if (!dl_ready_o) begin
			$display("dl_ready_o did not return high after %s", name);
			errors++;
		end
		tests_run++;
		$display("%s: %0d writes, %0s", name, writes_seen, (errors == err0) ? "ok" : "errors");
	endtask

	task automatic run_download(input string name, input cfg_word_u cfg, input logic [8:0] bank,
			input logic [15:0] load, input int len, input int base, input int gap);
		int         err0;
		int         t;
		int         limit;
		logic [7:0] b;
		err0 = errors;
		@(negedge clk_sys);
		cfg_i          = cfg;
		slot_gap       = gap;
		erase_mode     = 1'b0;
		prg_bank       = bank;
		load_addr      = load;
		prg_len        = len;
		pool_base      = base;
		expected_total = len + 4;
		writes_seen    = 0;
		@(negedge clk_sys);
		dl_active_i = 1'b1;
		// Two header bytes, then the payload
		for (int i = 0; i < len + 2; i++) begin
			@(negedge clk_sys);
			if (i == 0)
				b = load[7:0];
			else if (i == 1)
				b = load[15:8];
			else
				b = data_pool[8'(base + i - 2)];
			dl_valid_i = 1'b1;
			dl_byte_i  = b;
			t = 0;
			while (!dl_ready_o && t < 1000) begin
				@(negedge clk_sys);
				t++;
			end
			if (t >= 1000) begin
				report_timeout("dl_ready_o during the download");
				return;
			end
		end
		@(negedge clk_sys);
		dl_valid_i  = 1'b0;
		dl_active_i = 1'b0;
		limit = expected_total * 20 * gap + 200;
		t = 0;
		while (writes_seen < expected_total && t < limit) begin
			@(negedge clk_sys);
			t++;
		end
		if (t >= limit) begin
			report_timeout("the RAM writes of the download");
			return;
		end
		close_test(name, err0);
	endtask

	task automatic run_erase(input string name, input cfg_word_u cfg, input logic [24:0] first,
			input logic [24:0] last, input int gap);
		int   err0;
		int   t;
		int   limit;
		logic ready_seen;
		err0 = errors;
		@(negedge clk_sys);
		cfg_i          = cfg;
		slot_gap       = gap;
		erase_mode     = 1'b1;
		erase_first    = first;
		expected_total = int'(last - first) + 1;
		writes_seen    = 0;
		@(negedge clk_sys);
		erase_req_i = 1'b1;
		@(negedge clk_sys);
		erase_req_i = 1'b0;
		checks++;
		if (!erase_busy_o) begin
			$display("erase_busy_o did not rise after the erase request");
			errors++;
		end
		limit      = expected_total * 4 * gap + 1000;
		ready_seen = 1'b0;
		t          = 0;
		while (erase_busy_o && t < limit) begin
			if (dl_ready_o)
				ready_seen = 1'b1;
			@(negedge clk_sys);
			t++;
		end
		if (t >= limit) begin
			report_timeout("erase_busy_o to fall");
			return;
		end
		checks++;
		if (ready_seen) begin
			$display("dl_ready_o went high during the erase");
			errors++;
		end
		t = 0;
		while (writes_seen < expected_total && t < 1000) begin
			@(negedge clk_sys);
			t++;
		end
		if (t >= 1000) begin
			report_timeout("the last RAM writes of the erase");
			return;
		end
		close_test(name, err0);
	endtask

	// ==================================================================
	// Main sequence
	// ==================================================================
	initial begin
		int t;
		seed           = 32'h8d2f;
		RESET          = 1'b1;
		dl_active_i    = 1'b0;
		dl_valid_i     = 1'b0;
		dl_byte_i      = 8'h00;
		erase_req_i    = 1'b0;
		cfg_i          = '0;
		erase_mode     = 1'b0;
		prg_bank       = '0;
		load_addr      = '0;
		prg_len        = 0;
		pool_base      = 0;
		erase_first    = '0;
		expected_total = 0;
		writes_seen    = 0;
		errors         = 0;
		checks         = 0;
		tests_run      = 0;
		timed_out      = 1'b0;
		for (int i = 0; i < 256; i++)
			data_pool[8'(i)] = 8'($random(seed));

		repeat (8) @(negedge clk_sys);
		RESET = 1'b0;
		t = 0;
		while (!dl_ready_o && t < 100) begin
			@(negedge clk_sys);
			t++;
		end
		if (t >= 100)
			report_timeout("dl_ready_o after reset");

		if (!timed_out)
			run_download("test 1 P500 download", preset_cfg(SYS_P500), 9'd0, 16'h0401, 10, 0, 2);
		if (!timed_out)
			run_download("test 2 B610 download", preset_cfg(SYS_B610), 9'd1, 16'h0003, 10, 10, 2);
		if (!timed_out)
			run_download("test 3 custom B download", custom_cfg(2'b01, 2'd0), 9'd1, 16'h0003,
				10, 20, 2);
		if (!timed_out)
			run_erase("test 4 P 128K erase", preset_cfg(SYS_P500), 25'h000_0000, 25'h001_FFFF, 2);
		if (!timed_out)
			run_erase("test 5 custom 896K B erase", custom_cfg(2'b10, 2'd2), 25'h001_0000,
				25'h00E_FFFF, 2);
		// Payload crosses a page so the text end high byte differs from the start
		if (!timed_out)
			run_download("test 6 back-pressure", preset_cfg(SYS_B720), 9'd1, 16'h1CF0, 40, 30, 12);

		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0 && !timed_out)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
design/cbm_cfg_pkg.sv
design/mem_xfer_pkg.sv
design/sys_config_decode.sv
design/mem_write_gen.sv
design/write_fifo.sv
design/sdram_slot_writer.sv
design/cbm_loader_top.sv
tests/tb_cbm_loader_sva.sv
tests/tb_cbm_loader.sv

//--- Makefile
# Verilator simulation of the CBM-II memory loader

VERILATOR ?= verilator
TOP       ?= tb_cbm_loader
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
